// ==== csr_macros.svh ====
// Shared widths, CSR addresses, bit positions and reset values of the
// machine-mode CSR file. Included by every RTL source that needs them.
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_XLEN            32
`define CSR_ADDR_W          12
`define CSR_PC_W            30
`define CSR_CAUSE_W         4

`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344
`define CSR_ADDR_MCYCLE     12'hB00
`define CSR_ADDR_MINSTRET   12'hB02
`define CSR_ADDR_MCYCLEH    12'hB80
`define CSR_ADDR_MINSTRETH  12'hB82

// Field positions inside mstatus, MPP is the low bit of a two bit field
`define CSR_MSTATUS_MIE     3
`define CSR_MSTATUS_MPIE    7
`define CSR_MSTATUS_MPP     11

// Positions in mie and mip, which are also the interrupt cause codes
`define CSR_MSI_BIT         3
`define CSR_MTI_BIT         7
`define CSR_MEI_BIT         11

`define CSR_MTVEC_RESET     32'h0000_0000

`endif

// ==== csr_pkg.sv ====
// Types shared by the CSR file and its testbench.
// Referenced by scoped name, e.g. csr_pkg::csr_op_e.
package csr_pkg;

    // Encoding follows the low two bits of the CSR instruction funct3
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    // Register targeted by one access, SEL_NONE marks an illegal address
    typedef enum logic [3:0] {
        SEL_MSTATUS,
        SEL_MIE,
        SEL_MIP,
        SEL_MTVEC,
        SEL_MSCRATCH,
        SEL_MEPC,
        SEL_MCAUSE,
        SEL_MTVAL,
        SEL_MCYCLE,
        SEL_MCYCLEH,
        SEL_MINSTRET,
        SEL_MINSTRETH,
        SEL_NONE
    } csr_sel_e;

endpackage

// ==== csr_access.sv ====
// CSR access port. Decodes the address, forms the new register value from
// the opcode and broadcasts a one-cycle write strobe to the register owners.
// Done, exception and the old value are returned one cycle after the request.
`include "csr_macros.svh"

module csr_access (
    input  logic                     cpu_clock_i,
    input  logic                     rst_n_i,
    input  logic                     csr_valid_i,
    input  logic [`CSR_ADDR_W-1:0]   csr_addr_i,
    input  csr_pkg::csr_op_e         csr_op_i,
    input  logic                     csr_wr_en_i,
    input  logic [`CSR_XLEN-1:0]     csr_wdata_i,
    input  logic [`CSR_XLEN-1:0]     rd_mstatus_i,
    input  logic [2:0]               rd_mie_i,
    input  logic [`CSR_XLEN-1:0]     rd_mip_i,
    input  logic [`CSR_XLEN-1:0]     rd_mtvec_i,
    input  logic [`CSR_XLEN-1:0]     rd_mscratch_i,
    input  logic [`CSR_PC_W-1:0]     rd_mepc_i,
    input  logic [`CSR_XLEN-1:0]     rd_mcause_i,
    input  logic [`CSR_XLEN-1:0]     rd_mtval_i,
    input  logic [63:0]              rd_cycle_i,
    input  logic [63:0]              rd_instret_i,
    output logic                     csr_we_o,
    output csr_pkg::csr_sel_e        csr_sel_o,
    output logic [`CSR_XLEN-1:0]     csr_wval_o,
    output logic                     csr_done_o,
    output logic                     csr_excp_o,
    output logic [`CSR_XLEN-1:0]     csr_rdata_o
);

    csr_pkg::csr_sel_e     sel;
    logic [`CSR_XLEN-1:0]  cur_val;
    logic [`CSR_XLEN-1:0]  mie_word;

    always_comb begin
        case (csr_addr_i)
            `CSR_ADDR_MSTATUS:   sel = csr_pkg::SEL_MSTATUS;
            `CSR_ADDR_MIE:       sel = csr_pkg::SEL_MIE;
            `CSR_ADDR_MIP:       sel = csr_pkg::SEL_MIP;
            `CSR_ADDR_MTVEC:     sel = csr_pkg::SEL_MTVEC;
            `CSR_ADDR_MSCRATCH:  sel = csr_pkg::SEL_MSCRATCH;
            `CSR_ADDR_MEPC:      sel = csr_pkg::SEL_MEPC;
            `CSR_ADDR_MCAUSE:    sel = csr_pkg::SEL_MCAUSE;
            `CSR_ADDR_MTVAL:     sel = csr_pkg::SEL_MTVAL;
            `CSR_ADDR_MCYCLE:    sel = csr_pkg::SEL_MCYCLE;
            `CSR_ADDR_MCYCLEH:   sel = csr_pkg::SEL_MCYCLEH;
            `CSR_ADDR_MINSTRET:  sel = csr_pkg::SEL_MINSTRET;
            `CSR_ADDR_MINSTRETH: sel = csr_pkg::SEL_MINSTRETH;
            default:             sel = csr_pkg::SEL_NONE;
        endcase
    end

    // The three enable bits sit at their architectural positions in mie
    always_comb begin
        mie_word = '0;
        mie_word[`CSR_MSI_BIT] = rd_mie_i[0];
        mie_word[`CSR_MTI_BIT] = rd_mie_i[1];
        mie_word[`CSR_MEI_BIT] = rd_mie_i[2];
    end

    // An unimplemented address reads as zero
    always_comb begin
        case (sel)
            csr_pkg::SEL_MSTATUS:   cur_val = rd_mstatus_i;
            csr_pkg::SEL_MIE:       cur_val = mie_word;
            csr_pkg::SEL_MIP:       cur_val = rd_mip_i;
            csr_pkg::SEL_MTVEC:     cur_val = rd_mtvec_i;
            csr_pkg::SEL_MSCRATCH:  cur_val = rd_mscratch_i;
            csr_pkg::SEL_MEPC:      cur_val = {rd_mepc_i, 2'b00};
            csr_pkg::SEL_MCAUSE:    cur_val = rd_mcause_i;
            csr_pkg::SEL_MTVAL:     cur_val = rd_mtval_i;
            csr_pkg::SEL_MCYCLE:    cur_val = rd_cycle_i[31:0];
            csr_pkg::SEL_MCYCLEH:   cur_val = rd_cycle_i[63:32];
            csr_pkg::SEL_MINSTRET:  cur_val = rd_instret_i[31:0];
            csr_pkg::SEL_MINSTRETH: cur_val = rd_instret_i[63:32];
            default:                cur_val = '0;
        endcase
    end

    always_comb begin
        case (csr_op_i)
            csr_pkg::CSR_RW: csr_wval_o = csr_wdata_i;
            csr_pkg::CSR_RS: csr_wval_o = cur_val | csr_wdata_i;
            csr_pkg::CSR_RC: csr_wval_o = cur_val & ~csr_wdata_i;
            default:         csr_wval_o = cur_val;
        endcase
    end

    assign csr_sel_o = sel;
    assign csr_we_o  = csr_valid_i & csr_wr_en_i & (sel != csr_pkg::SEL_NONE);

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            csr_done_o <= 1'b0;
            csr_excp_o <= 1'b0;
        end else begin
            csr_done_o <= csr_valid_i;
            csr_excp_o <= csr_valid_i & (sel == csr_pkg::SEL_NONE);
        end
    end

    // Captured before the owners update, so it carries the old value
    always_ff @(posedge cpu_clock_i) begin
        if (csr_valid_i) begin
            csr_rdata_o <= cur_val;
        end
    end

endmodule

// ==== trap_ctrl.sv ====
// Trap registers of machine mode: mstatus, mie, mtvec, mscratch, mepc,
// mcause and mtval. Handles software writes, trap entry and mret.
`include "csr_macros.svh"

module trap_ctrl (
    input  logic                     cpu_clock_i,
    input  logic                     rst_n_i,
    input  logic                     csr_we_i,
    input  csr_pkg::csr_sel_e        csr_sel_i,
    input  logic [`CSR_XLEN-1:0]     csr_wval_i,
    input  logic                     take_exception_i,
    input  logic                     take_interrupt_i,
    input  logic                     mret_i,
    input  logic [`CSR_PC_W-1:0]     epc_i,
    input  logic [`CSR_XLEN-1:0]     mtval_i,
    input  logic [`CSR_CAUSE_W-1:0]  exc_cause_i,
    input  logic [`CSR_CAUSE_W-1:0]  int_cause_i,
    output logic [`CSR_XLEN-1:0]     mstatus_o,
    output logic [2:0]               mie_en_o,
    output logic [`CSR_XLEN-1:0]     mtvec_o,
    output logic [`CSR_XLEN-1:0]     mscratch_o,
    output logic [`CSR_PC_W-1:0]     mepc_o,
    output logic [`CSR_XLEN-1:0]     mcause_o,
    output logic [`CSR_XLEN-1:0]     mtval_o,
    output logic                     mie_o
);

    logic                     status_mie;
    logic                     status_mpie;
    logic                     cause_int;
    logic [`CSR_CAUSE_W-1:0]  cause_code;

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
            mie_en_o    <= '0;
            mtvec_o     <= `CSR_MTVEC_RESET;
            mscratch_o  <= '0;
            mepc_o      <= '0;
            cause_int   <= 1'b0;
            cause_code  <= '0;
            mtval_o     <= '0;
        end else begin
            if (csr_we_i) begin
                case (csr_sel_i)
                    csr_pkg::SEL_MSTATUS: begin
                        status_mie  <= csr_wval_i[`CSR_MSTATUS_MIE];
                        status_mpie <= csr_wval_i[`CSR_MSTATUS_MPIE];
                    end
                    csr_pkg::SEL_MIE: begin
                        mie_en_o <= {csr_wval_i[`CSR_MEI_BIT], csr_wval_i[`CSR_MTI_BIT],
                                     csr_wval_i[`CSR_MSI_BIT]};
                    end
                    csr_pkg::SEL_MTVEC:    mtvec_o    <= {csr_wval_i[`CSR_XLEN-1:2], 2'b00};
                    csr_pkg::SEL_MSCRATCH: mscratch_o <= csr_wval_i;
                    csr_pkg::SEL_MEPC:     mepc_o     <= csr_wval_i[`CSR_XLEN-1:2];
                    csr_pkg::SEL_MCAUSE: begin
                        cause_int  <= csr_wval_i[`CSR_XLEN-1];
                        cause_code <= csr_wval_i[`CSR_CAUSE_W-1:0];
                    end
                    csr_pkg::SEL_MTVAL:    mtval_o    <= csr_wval_i;
                    default: ;
                endcase
            end

            // Trap events come last so they override a same-cycle software write
            if (take_exception_i) begin
                mepc_o      <= epc_i;
                cause_int   <= 1'b0;
                cause_code  <= exc_cause_i;
                mtval_o     <= mtval_i;
                status_mpie <= status_mie;
                status_mie  <= 1'b0;
            end else if (take_interrupt_i) begin
                mepc_o      <= epc_i;
                cause_int   <= 1'b1;
                cause_code  <= int_cause_i;
                mtval_o     <= '0;
                status_mpie <= status_mie;
                status_mie  <= 1'b0;
            end else if (mret_i) begin
                status_mie  <= status_mpie;
                status_mpie <= 1'b1;
            end
        end
    end

    // MPP is hardwired to machine mode
    always_comb begin
        mstatus_o = '0;
        mstatus_o[`CSR_MSTATUS_MIE]      = status_mie;
        mstatus_o[`CSR_MSTATUS_MPIE]     = status_mpie;
        mstatus_o[`CSR_MSTATUS_MPP +: 2] = 2'b11;
    end

    assign mcause_o = {cause_int, {(`CSR_XLEN-1-`CSR_CAUSE_W){1'b0}}, cause_code};
    assign mie_o    = status_mie;

endmodule

// ==== irq_pending.sv ====
// Interrupt pending logic. Brings the software, timer and external lines
// through a two-flop synchronizer into mip and raises the request with
// the cause of the highest-priority enabled line.
`include "csr_macros.svh"

module irq_pending (
    input  logic                     cpu_clock_i,
    input  logic                     rst_n_i,
    input  logic [2:0]               ext_int_i,
    input  logic [2:0]               mie_en_i,
    input  logic                     mie_i,
    output logic [`CSR_XLEN-1:0]     mip_o,
    output logic                     irq_req_o,
    output logic [`CSR_CAUSE_W-1:0]  int_cause_o
);

    logic [2:0] sync_meta;
    logic [2:0] pend;
    logic [2:0] active;

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            sync_meta <= '0;
            pend      <= '0;
        end else begin
            sync_meta <= ext_int_i;
            pend      <= sync_meta;
        end
    end

    always_comb begin
        mip_o = '0;
        mip_o[`CSR_MSI_BIT] = pend[0];
        mip_o[`CSR_MTI_BIT] = pend[1];
        mip_o[`CSR_MEI_BIT] = pend[2];
    end

    assign active    = pend & mie_en_i;
    assign irq_req_o = mie_i & (|active);

    // External first, then software, then timer
    always_comb begin
        if (active[2]) begin
            int_cause_o = `CSR_CAUSE_W'(`CSR_MEI_BIT);
        end else if (active[0]) begin
            int_cause_o = `CSR_CAUSE_W'(`CSR_MSI_BIT);
        end else begin
            int_cause_o = `CSR_CAUSE_W'(`CSR_MTI_BIT);
        end
    end

endmodule

// ==== retire_counters.sv ====
// 64-bit mcycle and minstret counters. Up to two instructions retire per
// cycle. A software write to either half replaces it and holds off the
// increment for that cycle.
`include "csr_macros.svh"

module retire_counters (
    input  logic                  cpu_clock_i,
    input  logic                  rst_n_i,
    input  logic                  csr_we_i,
    input  csr_pkg::csr_sel_e     csr_sel_i,
    input  logic [`CSR_XLEN-1:0]  csr_wval_i,
    input  logic                  commit0_i,
    input  logic                  commit1_i,
    output logic [63:0]           cycle_o,
    output logic [63:0]           instret_o
);

    logic [1:0]  commit_sum;
    logic [63:0] cycle_d;
    logic [63:0] instret_d;

    assign commit_sum = {1'b0, commit0_i} + {1'b0, commit1_i};

    always_comb begin
        cycle_d   = cycle_o + 64'd1;
        instret_d = instret_o + {62'd0, commit_sum};
        if (csr_we_i) begin
            case (csr_sel_i)
                csr_pkg::SEL_MCYCLE:    cycle_d   = {cycle_o[63:32], csr_wval_i};
                csr_pkg::SEL_MCYCLEH:   cycle_d   = {csr_wval_i, cycle_o[31:0]};
                csr_pkg::SEL_MINSTRET:  instret_d = {instret_o[63:32], csr_wval_i};
                csr_pkg::SEL_MINSTRETH: instret_d = {csr_wval_i, instret_o[31:0]};
                default: ;
            endcase
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            cycle_o   <= '0;
            instret_o <= '0;
        end else begin
            cycle_o   <= cycle_d;
            instret_o <= instret_d;
        end
    end

endmodule

// ==== machine_csr_file.sv ====
// Machine-mode CSR file of the dual-issue core. Connects the access port,
// the trap registers, the interrupt pending logic and the counters.
`include "csr_macros.svh"

module machine_csr_file (
    input  logic                     cpu_clock_i,
    input  logic                     rst_n_i,
    input  logic                     csr_valid_i,
    input  logic [`CSR_ADDR_W-1:0]   csr_addr_i,
    input  csr_pkg::csr_op_e         csr_op_i,
    input  logic                     csr_wr_en_i,
    input  logic [`CSR_XLEN-1:0]     csr_wdata_i,
    input  logic                     take_exception_i,
    input  logic                     take_interrupt_i,
    input  logic                     mret_i,
    input  logic [`CSR_PC_W-1:0]     epc_i,
    input  logic [`CSR_XLEN-1:0]     mtval_i,
    input  logic [`CSR_CAUSE_W-1:0]  exc_cause_i,
    input  logic                     commit0_i,
    input  logic                     commit1_i,
    input  logic [2:0]               ext_int_i,
    output logic                     csr_done_o,
    output logic                     csr_excp_o,
    output logic [`CSR_XLEN-1:0]     csr_rdata_o,
    output logic [`CSR_PC_W-1:0]     mepc_o,
    output logic [`CSR_XLEN-1:0]     mtvec_o,
    output logic                     mie_o,
    output logic                     irq_req_o
);

    logic                     csr_we;
    csr_pkg::csr_sel_e        csr_sel;
    logic [`CSR_XLEN-1:0]     csr_wval;
    logic [`CSR_XLEN-1:0]     mstatus;
    logic [2:0]               mie_en;
    logic [`CSR_XLEN-1:0]     mscratch;
    logic [`CSR_XLEN-1:0]     mcause;
    logic [`CSR_XLEN-1:0]     mtval;
    logic [`CSR_XLEN-1:0]     mip;
    logic [`CSR_CAUSE_W-1:0]  int_cause;
    logic [63:0]              cycle;
    logic [63:0]              instret;

    csr_access u_access (
        .cpu_clock_i   (cpu_clock_i),
        .rst_n_i       (rst_n_i),
        .csr_valid_i   (csr_valid_i),
        .csr_addr_i    (csr_addr_i),
        .csr_op_i      (csr_op_i),
        .csr_wr_en_i   (csr_wr_en_i),
        .csr_wdata_i   (csr_wdata_i),
        .rd_mstatus_i  (mstatus),
        .rd_mie_i      (mie_en),
        .rd_mip_i      (mip),
        .rd_mtvec_i    (mtvec_o),
        .rd_mscratch_i (mscratch),
        .rd_mepc_i     (mepc_o),
        .rd_mcause_i   (mcause),
        .rd_mtval_i    (mtval),
        .rd_cycle_i    (cycle),
        .rd_instret_i  (instret),
        .csr_we_o      (csr_we),
        .csr_sel_o     (csr_sel),
        .csr_wval_o    (csr_wval),
        .csr_done_o    (csr_done_o),
        .csr_excp_o    (csr_excp_o),
        .csr_rdata_o   (csr_rdata_o)
    );

    trap_ctrl u_trap (
        .cpu_clock_i      (cpu_clock_i),
        .rst_n_i          (rst_n_i),
        .csr_we_i         (csr_we),
        .csr_sel_i        (csr_sel),
        .csr_wval_i       (csr_wval),
        .take_exception_i (take_exception_i),
        .take_interrupt_i (take_interrupt_i),
        .mret_i           (mret_i),
        .epc_i            (epc_i),
        .mtval_i          (mtval_i),
        .exc_cause_i      (exc_cause_i),
        .int_cause_i      (int_cause),
        .mstatus_o        (mstatus),
        .mie_en_o         (mie_en),
        .mtvec_o          (mtvec_o),
        .mscratch_o       (mscratch),
        .mepc_o           (mepc_o),
        .mcause_o         (mcause),
        .mtval_o          (mtval),
        .mie_o            (mie_o)
    );

    irq_pending u_irq (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .ext_int_i   (ext_int_i),
        .mie_en_i    (mie_en),
        .mie_i       (mie_o),
        .mip_o       (mip),
        .irq_req_o   (irq_req_o),
        .int_cause_o (int_cause)
    );

    retire_counters u_counters (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .csr_we_i    (csr_we),
        .csr_sel_i   (csr_sel),
        .csr_wval_i  (csr_wval),
        .commit0_i   (commit0_i),
        .commit1_i   (commit1_i),
        .cycle_o     (cycle),
        .instret_o   (instret)
    );

endmodule

// ==== tb_clock_gen.sv ====
// Clock and reset source for the CSR file testbench.
// Makes a 10 ns clock and holds the active-low reset for eight cycles.
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

    always #5 clk_o = ~clk_o;

endmodule

// ==== tb_machine_csr_file.sv ====
// Testbench for the machine-mode CSR file. Runs CSR accesses, traps,
// interrupts and counter checks against a small reference model.
`include "csr_macros.svh"

module tb_machine_csr_file;
    timeunit 1ns;
    timeprecision 1ps;

    logic                     cpu_clock;
    logic                     rst_n;
    logic                     csr_valid_i;
    logic [`CSR_ADDR_W-1:0]   csr_addr_i;
    csr_pkg::csr_op_e         csr_op_i;
    logic                     csr_wr_en_i;
    logic [`CSR_XLEN-1:0]     csr_wdata_i;
    logic                     take_exception_i;
    logic                     take_interrupt_i;
    logic                     mret_i;
    logic [`CSR_PC_W-1:0]     epc_i;
    logic [`CSR_XLEN-1:0]     mtval_i;
    logic [`CSR_CAUSE_W-1:0]  exc_cause_i;
    logic                     commit0_i;
    logic                     commit1_i;
    logic [2:0]               ext_int_i;
    logic                     csr_done_o;
    logic                     csr_excp_o;
    logic [`CSR_XLEN-1:0]     csr_rdata_o;
    logic [`CSR_PC_W-1:0]     mepc_o;
    logic [`CSR_XLEN-1:0]     mtvec_o;
    logic                     mie_o;
    logic                     irq_req_o;
    logic [31:0]              lcg_state;

    tb_clock_gen u_clock (
        .clk_o   (cpu_clock),
        .rst_n_o (rst_n)
    );

    machine_csr_file uut (
        .cpu_clock_i      (cpu_clock),
        .rst_n_i          (rst_n),
        .csr_valid_i      (csr_valid_i),
        .csr_addr_i       (csr_addr_i),
        .csr_op_i         (csr_op_i),
        .csr_wr_en_i      (csr_wr_en_i),
        .csr_wdata_i      (csr_wdata_i),
        .take_exception_i (take_exception_i),
        .take_interrupt_i (take_interrupt_i),
        .mret_i           (mret_i),
        .epc_i            (epc_i),
        .mtval_i          (mtval_i),
        .exc_cause_i      (exc_cause_i),
        .commit0_i        (commit0_i),
        .commit1_i        (commit1_i),
        .ext_int_i        (ext_int_i),
        .csr_done_o       (csr_done_o),
        .csr_excp_o       (csr_excp_o),
        .csr_rdata_o      (csr_rdata_o),
        .mepc_o           (mepc_o),
        .mtvec_o          (mtvec_o),
        .mie_o            (mie_o),
        .irq_req_o        (irq_req_o)
    );

    task automatic stop_on_failure();
        $display("sim failed");
        $fatal(1, "stopped at first failure");
    endtask

    // Every request answers with done exactly one cycle later, and only then
    assert property (@(posedge cpu_clock) disable iff (!rst_n) csr_valid_i |=> csr_done_o)
        else begin
            $display("csr_done_o did not pulse one cycle after csr_valid_i");
            stop_on_failure();
        end

    assert property (@(posedge cpu_clock) disable iff (!rst_n) !csr_valid_i |=> !csr_done_o)
        else begin
            $display("csr_done_o pulsed without a request one cycle earlier");
            stop_on_failure();
        end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
            else begin
                $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
                stop_on_failure();
            end
    endtask

    // One access on the CSR port that returns what the DUT answers with done
    task automatic run_csr(input logic [11:0] addr, input csr_pkg::csr_op_e op,
                           input logic wr_en, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic excp);
        int waited;
        @(posedge cpu_clock);
        #1;
        csr_valid_i = 1'b1;
        csr_addr_i  = addr;
        csr_op_i    = op;
        csr_wr_en_i = wr_en;
        csr_wdata_i = wdata;
        @(posedge cpu_clock);
        #1;
        csr_valid_i = 1'b0;
        csr_wr_en_i = 1'b0;
        waited = 0;
        while (!csr_done_o && waited < 20) begin
            @(posedge cpu_clock);
            #1;
            waited++;
        end
        if (!csr_done_o) begin
            $display("Timeout while waiting for csr_done_o, address %h", addr);
            stop_on_failure();
        end
        rdata = csr_rdata_o;
        excp  = csr_excp_o;
    endtask

    task automatic modify_csr(input string name, input logic [11:0] addr,
                              input csr_pkg::csr_op_e op, input logic wr_en,
                              input logic [31:0] wdata, input logic [31:0] expected_old);
        logic [31:0] rdata;
        logic        excp;
        run_csr(addr, op, wr_en, wdata, rdata, excp);
        check_value({name, " excp"}, 32'd0, {31'd0, excp});
        check_value({name, " rdata"}, expected_old, rdata);
    endtask

    task automatic read_csr(input string name, input logic [11:0] addr,
                            input logic [31:0] expected);
        modify_csr(name, addr, csr_pkg::CSR_RS, 1'b0, 32'd0, expected);
    endtask

    // Drives the trap lines for exactly one clock edge
    task automatic pulse_event(input logic exc, input logic irq, input logic ret);
        @(posedge cpu_clock);
        #1;
        take_exception_i = exc;
        take_interrupt_i = irq;
        mret_i           = ret;
        @(posedge cpu_clock);
        #1;
        take_exception_i = 1'b0;
        take_interrupt_i = 1'b0;
        mret_i           = 1'b0;
    endtask

    initial begin
        logic [31:0] model;
        logic [31:0] val;
        logic [31:0] rdata;
        logic [31:0] first_cycle;
        logic        excp;
        logic [29:0] epc;
        logic [3:0]  cause;
        logic [31:0] tval;
        int          n_commit;
        int          waited;

        lcg_state        = 32'd78;
        csr_valid_i      = 1'b0;
        csr_addr_i       = '0;
        csr_op_i         = csr_pkg::CSR_RW;
        csr_wr_en_i      = 1'b0;
        csr_wdata_i      = '0;
        take_exception_i = 1'b0;
        take_interrupt_i = 1'b0;
        mret_i           = 1'b0;
        epc_i            = '0;
        mtval_i          = '0;
        exc_cause_i      = '0;
        commit0_i        = 1'b0;
        commit1_i        = 1'b0;
        ext_int_i        = 3'b000;

        waited = 0;
        while (rst_n !== 1'b1 && waited < 50) begin
            @(posedge cpu_clock);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout while waiting for reset release");
            stop_on_failure();
        end

        // mscratch holds any value
        val = next_random();
        modify_csr("mscratch write", `CSR_ADDR_MSCRATCH, csr_pkg::CSR_RW, 1'b1, val, 32'd0);
        model = val;
        read_csr("mscratch after write", `CSR_ADDR_MSCRATCH, model);
        val = next_random();
        modify_csr("mscratch set", `CSR_ADDR_MSCRATCH, csr_pkg::CSR_RS, 1'b1, val, model);
        model = model | val;
        read_csr("mscratch after set", `CSR_ADDR_MSCRATCH, model);
        val = next_random();
        modify_csr("mscratch clear", `CSR_ADDR_MSCRATCH, csr_pkg::CSR_RC, 1'b1, val, model);
        model = model & ~val;
        read_csr("mscratch after clear", `CSR_ADDR_MSCRATCH, model);
        val = next_random();
        modify_csr("mscratch set no wr", `CSR_ADDR_MSCRATCH, csr_pkg::CSR_RS, 1'b0, val, model);
        modify_csr("mscratch clear no wr", `CSR_ADDR_MSCRATCH, csr_pkg::CSR_RC, 1'b0, val, model);
        read_csr("mscratch unchanged", `CSR_ADDR_MSCRATCH, model);

        // mtvec keeps its low two bits at zero
        val = next_random() | 32'h3;
        modify_csr("mtvec write", `CSR_ADDR_MTVEC, csr_pkg::CSR_RW, 1'b1, val, 32'd0);
        model = val & ~32'h3;
        read_csr("mtvec after write", `CSR_ADDR_MTVEC, model);
        val = next_random();
        modify_csr("mtvec set", `CSR_ADDR_MTVEC, csr_pkg::CSR_RS, 1'b1, val, model);
        model = (model | val) & ~32'h3;
        read_csr("mtvec after set", `CSR_ADDR_MTVEC, model);
        check_value("mtvec_o port", model, mtvec_o);
        val = next_random();
        modify_csr("mtvec clear", `CSR_ADDR_MTVEC, csr_pkg::CSR_RC, 1'b1, val, model);
        model = model & ~val;
        read_csr("mtvec after clear", `CSR_ADDR_MTVEC, model);
        modify_csr("mtvec set no wr", `CSR_ADDR_MTVEC, csr_pkg::CSR_RS, 1'b0, 32'hFFFF_FFFF, model);
        read_csr("mtvec unchanged", `CSR_ADDR_MTVEC, model);

        // Unimplemented address and read-only mip
        run_csr(12'h7C0, csr_pkg::CSR_RW, 1'b1, next_random(), rdata, excp);
        check_value("illegal address excp", 32'd1, {31'd0, excp});
        check_value("illegal address rdata", 32'd0, rdata);
        modify_csr("mip write", `CSR_ADDR_MIP, csr_pkg::CSR_RW, 1'b1, 32'hFFFF_FFFF, 32'd0);
        read_csr("mip after write", `CSR_ADDR_MIP, 32'd0);

        // Exception entry and return where MPP always reads 3
        modify_csr("mstatus set MIE", `CSR_ADDR_MSTATUS, csr_pkg::CSR_RS, 1'b1, 32'h8, 32'h1800);
        val   = next_random();
        epc   = val[31:2];
        val   = next_random();
        cause = val[27:24];
        tval  = next_random();
        epc_i       = epc;
        exc_cause_i = cause;
        mtval_i     = tval;
        pulse_event(1'b1, 1'b0, 1'b0);
        check_value("mepc_o after exception", {2'b00, epc}, {2'b00, mepc_o});
        read_csr("mepc after exception", `CSR_ADDR_MEPC, {epc, 2'b00});
        read_csr("mcause after exception", `CSR_ADDR_MCAUSE, {28'd0, cause});
        read_csr("mtval after exception", `CSR_ADDR_MTVAL, tval);
        read_csr("mstatus after exception", `CSR_ADDR_MSTATUS, 32'h1880);
        pulse_event(1'b0, 1'b0, 1'b1);
        check_value("mie_o after mret", 32'd1, {31'd0, mie_o});
        read_csr("mstatus after mret", `CSR_ADDR_MSTATUS, 32'h1888);

        // Timer interrupt through the synchronizer
        modify_csr("mie enable MTIE", `CSR_ADDR_MIE, csr_pkg::CSR_RW, 1'b1, 32'h80, 32'd0);
        modify_csr("mstatus keep MIE", `CSR_ADDR_MSTATUS, csr_pkg::CSR_RS, 1'b1, 32'h8, 32'h1888);
        @(posedge cpu_clock);
        #1;
        ext_int_i = 3'b010;
        waited = 0;
        while (!irq_req_o && waited < 10) begin
            @(posedge cpu_clock);
            #1;
            waited++;
        end
        if (!irq_req_o) begin
            $display("Timeout while waiting for irq_req_o after the timer line rose");
            stop_on_failure();
        end
        read_csr("mip timer pending", `CSR_ADDR_MIP, 32'h80);
        val   = next_random();
        epc_i = val[31:2];
        pulse_event(1'b0, 1'b1, 1'b0);
        check_value("mie_o after interrupt", 32'd0, {31'd0, mie_o});
        check_value("irq_req_o after interrupt", 32'd0, {31'd0, irq_req_o});
        read_csr("mcause after interrupt", `CSR_ADDR_MCAUSE, 32'h8000_0007);
        ext_int_i = 3'b000;

        // Retired instructions with every commit pair, two at most per cycle
        modify_csr("minstret clear", `CSR_ADDR_MINSTRET, csr_pkg::CSR_RW, 1'b1, 32'd0, 32'd0);
        modify_csr("minstreth clear", `CSR_ADDR_MINSTRETH, csr_pkg::CSR_RW, 1'b1, 32'd0, 32'd0);
        n_commit = 0;
        for (int i = 0; i < 12; i++) begin
            @(posedge cpu_clock);
            #1;
            commit0_i = i[0];
            commit1_i = i[1];
            n_commit = n_commit + int'(i[0]) + int'(i[1]);
        end
        @(posedge cpu_clock);
        #1;
        commit0_i = 1'b0;
        commit1_i = 1'b0;
        read_csr("minstret count", `CSR_ADDR_MINSTRET, n_commit);
        read_csr("minstreth count", `CSR_ADDR_MINSTRETH, 32'd0);

        run_csr(`CSR_ADDR_MCYCLE, csr_pkg::CSR_RS, 1'b0, 32'd0, first_cycle, excp);
        run_csr(`CSR_ADDR_MCYCLE, csr_pkg::CSR_RS, 1'b0, 32'd0, rdata, excp);
        assert (rdata > first_cycle)
            else begin
                $display("[ERROR] mcycle increase: expected above %h, actual %h",
                         first_cycle, rdata);
                stop_on_failure();
            end

        $display("sim passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
csr_pkg.sv
csr_access.sv
trap_ctrl.sv
irq_pending.sv
retire_counters.sv
machine_csr_file.sv
tb_clock_gen.sv
tb_machine_csr_file.sv

// ==== Bender.yml ====
package:
  name: machine_csr_file

export_include_dirs:
  - .

sources:
  - files:
      - csr_pkg.sv
      - csr_access.sv
      - trap_ctrl.sv
      - irq_pending.sv
      - retire_counters.sv
      - machine_csr_file.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_machine_csr_file.sv
